//--- hdl/video_gen_pkg.sv
// ####################
// video generator shared timing, register numbers and types
// ####################
`default_nettype none

package video_gen_pkg;

    // tiny display mode so that a frame simulates quickly
    localparam int H_FRONT_PORCH   = 4;
    localparam int H_SYNC_PULSE    = 8;
    localparam int OFFSCREEN_WIDTH = 24;
    localparam int VISIBLE_WIDTH   = 64;
    localparam int TOTAL_WIDTH     = 88;
    localparam int VISIBLE_HEIGHT  = 6;
    localparam int V_FRONT_PORCH   = 1;
    localparam int V_SYNC_PULSE    = 2;
    localparam int TOTAL_HEIGHT    = 10;
    localparam int H_MEM_BEGIN     = OFFSCREEN_WIDTH - 16;   // prefetch ahead of first pixel

    localparam logic H_SYNC_POLARITY = 1'b1;
    localparam logic V_SYNC_POLARITY = 1'b1;

    localparam int COUNT_W = 11;

    typedef logic [15:0] vram_addr_t;
    typedef logic [15:0] vram_data_t;
    typedef logic [7:0]  pal_index_t;
    typedef logic [3:0]  reg_num_t;

    localparam reg_num_t REG_DISPSTART  = 4'd0;
    localparam reg_num_t REG_DISPWIDTH  = 4'd1;
    localparam reg_num_t REG_GFXCTRL    = 4'd2;
    localparam reg_num_t REG_R_WIDTH    = 4'd8;    // read only
    localparam reg_num_t REG_R_HEIGHT   = 4'd9;    // read only
    localparam reg_num_t REG_R_SCANLINE = 4'd11;   // read only

    // sync phases in scan order, VISIBLE wraps back to PRE_SYNC
    typedef enum logic [1:0] {
        PRE_SYNC  = 2'b00,
        SYNC      = 2'b01,
        POST_SYNC = 2'b10,
        VISIBLE   = 2'b11
    } sync_state_t;

    typedef enum logic {
        BPP_4 = 1'b0,
        BPP_8 = 1'b1
    } bpp_t;

    typedef struct packed {
        vram_addr_t  start_addr;
        logic [15:0] line_width;   // words per line
        logic [7:0]  colorbase;
        bpp_t        bpp;
    } video_cfg_t;

    typedef struct packed {
        logic               fetch_active;       // fetch window, enabled frames only
        logic               line_fetch_start;   // cycle before the window opens
        logic               scanout_start;      // first visible column minus one
        logic               line_end;
        logic               frame_start;        // last pixel of the frame
        logic               last_visible;       // last pixel of last visible line
        logic               visible;            // pixel shown this cycle
        logic               h_visible;
        logic               v_visible;
        logic [COUNT_W-1:0] scanline;
    } timing_ev_t;

    // [7] is the leftmost pixel
    typedef pal_index_t [7:0] pixel_group_t;

endpackage

`default_nettype wire

//--- hdl/video_regs.sv
// ####################
// configuration registers and register readback
// ####################
`default_nettype none
`timescale 1ns/10ps

module video_regs (
    input  wire logic                              clk,
    input  wire logic                              reset_i,
    input  wire logic                              reg_wr_i,
    input  wire video_gen_pkg::reg_num_t           reg_num_i,
    input  wire video_gen_pkg::vram_data_t         reg_data_i,
    input  wire logic [video_gen_pkg::COUNT_W-1:0] v_count_i,
    input  wire logic                              v_visible_i,
    input  wire logic                              h_visible_i,
    output      video_gen_pkg::vram_data_t         reg_data_o,
    output      video_gen_pkg::video_cfg_t         cfg_o
);
    import video_gen_pkg::*;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            cfg_o.start_addr <= '0;
            cfg_o.line_width <= 16'(VISIBLE_WIDTH / 2);   // 8 bpp line
            cfg_o.colorbase  <= '0;
            cfg_o.bpp        <= BPP_8;
        end else if (reg_wr_i) begin
            case (reg_num_i)
                REG_DISPSTART: begin
                    cfg_o.start_addr <= reg_data_i;
                end
                REG_DISPWIDTH: begin
                    cfg_o.line_width <= reg_data_i;
                end
                REG_GFXCTRL: begin
                    cfg_o.colorbase <= reg_data_i[15:8];
                    cfg_o.bpp       <= bpp_t'(reg_data_i[4]);
                end
                default: begin
                end
            endcase
        end
    end

    // readback one cycle after the number is presented
    always_ff @(posedge clk) begin
        case (reg_num_i)
            REG_DISPSTART:  reg_data_o <= cfg_o.start_addr;
            REG_DISPWIDTH:  reg_data_o <= cfg_o.line_width;
            REG_GFXCTRL:    reg_data_o <= {cfg_o.colorbase, 3'b000, cfg_o.bpp, 4'h0};
            REG_R_WIDTH:    reg_data_o <= 16'(VISIBLE_WIDTH);
            REG_R_HEIGHT:   reg_data_o <= 16'(VISIBLE_HEIGHT);
            REG_R_SCANLINE: reg_data_o <= {~v_visible_i, ~h_visible_i, 3'b000, v_count_i};
            default:        reg_data_o <= '0;
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/video_timing.sv
// ####################
// sync state machines, counters and line/frame events
// ####################
`default_nettype none
`timescale 1ns/10ps

module video_timing (
    input  wire logic                       clk,
    input  wire logic                       reset_i,
    input  wire logic                       enable_i,
    output      video_gen_pkg::timing_ev_t  ev_o,
    output      logic                       hsync_o,
    output      logic                       vsync_o,
    output      logic                       dv_de_o,
    output      logic                       bus_intr_o
);
    import video_gen_pkg::*;

    sync_state_t        h_state;
    sync_state_t        v_state;
    logic [COUNT_W-1:0] h_count;
    logic [COUNT_W-1:0] v_count;
    logic [COUNT_W-1:0] h_thresh;   // last count of current h phase
    logic [COUNT_W-1:0] v_thresh;
    logic               v_step;
    logic               vg_enable;
    logic               fetch_active;

    always_comb begin
        case (h_state)
            PRE_SYNC:  h_thresh = COUNT_W'(H_FRONT_PORCH - 1);
            SYNC:      h_thresh = COUNT_W'(H_FRONT_PORCH + H_SYNC_PULSE - 1);
            POST_SYNC: h_thresh = COUNT_W'(OFFSCREEN_WIDTH - 1);
            default:   h_thresh = COUNT_W'(TOTAL_WIDTH - 1);
        endcase
        // visible lines come first, blanking at the bottom
        case (v_state)
            PRE_SYNC:  v_thresh = COUNT_W'(VISIBLE_HEIGHT + V_FRONT_PORCH - 1);
            SYNC:      v_thresh = COUNT_W'(VISIBLE_HEIGHT + V_FRONT_PORCH + V_SYNC_PULSE - 1);
            POST_SYNC: v_thresh = COUNT_W'(TOTAL_HEIGHT - 1);
            default:   v_thresh = COUNT_W'(VISIBLE_HEIGHT - 1);
        endcase
    end

    always_comb begin
        ev_o.line_end         = (h_state == VISIBLE) && (h_count == h_thresh);
        v_step                = ev_o.line_end && (v_count == v_thresh);
        ev_o.frame_start      = v_step && (v_state == POST_SYNC);
        ev_o.last_visible     = v_step && (v_state == VISIBLE);
        ev_o.h_visible        = (h_state == VISIBLE);
        ev_o.v_visible        = (v_state == VISIBLE);
        ev_o.visible          = vg_enable && ev_o.h_visible && ev_o.v_visible;
        ev_o.line_fetch_start = vg_enable && ev_o.v_visible
                                && (h_count == COUNT_W'(H_MEM_BEGIN - 1));
        ev_o.scanout_start    = vg_enable && ev_o.v_visible
                                && (h_count == COUNT_W'(OFFSCREEN_WIDTH - 1));
        ev_o.fetch_active     = fetch_active;
        ev_o.scanline         = v_count;
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            h_state      <= PRE_SYNC;
            h_count      <= '0;
            v_state      <= POST_SYNC;                   // last blank line, frame starts soon
            v_count      <= COUNT_W'(TOTAL_HEIGHT - 1);
            vg_enable    <= 1'b1;
            fetch_active <= 1'b0;
            hsync_o      <= ~H_SYNC_POLARITY;
            vsync_o      <= ~V_SYNC_POLARITY;
            dv_de_o      <= 1'b0;
            bus_intr_o   <= 1'b0;
        end else begin
            if (h_count == h_thresh) begin
                h_state <= sync_state_t'(h_state + 1'b1);
            end
            if (v_step) begin
                v_state <= sync_state_t'(v_state + 1'b1);
            end

            h_count <= ev_o.line_end ? '0 : h_count + 1'b1;
            if (ev_o.frame_start) begin
                v_count   <= '0;
                vg_enable <= enable_i;                   // frame level enable
            end else if (ev_o.line_end) begin
                v_count <= v_count + 1'b1;
            end

            if (ev_o.line_end) begin
                fetch_active <= 1'b0;
            end else if (ev_o.line_fetch_start) begin
                fetch_active <= 1'b1;
            end

            hsync_o    <= (h_state == SYNC) ? H_SYNC_POLARITY : ~H_SYNC_POLARITY;
            vsync_o    <= (v_state == SYNC) ? V_SYNC_POLARITY : ~V_SYNC_POLARITY;
            dv_de_o    <= ev_o.visible;
            bus_intr_o <= ev_o.last_visible;
        end
    end

    // display enable never overlaps a sync pulse
    assert property (@(posedge clk) disable iff (reset_i)
        dv_de_o |-> (hsync_o != H_SYNC_POLARITY) && (vsync_o != V_SYNC_POLARITY));

endmodule

`default_nettype wire

//--- hdl/pixel_fetch.sv
// ####################
// VRAM address walk and 8-cycle fetch slots building pixel groups
// ####################
`default_nettype none
`timescale 1ns/10ps

module pixel_fetch (
    input  wire logic                         clk,
    input  wire logic                         reset_i,
    input  wire video_gen_pkg::video_cfg_t    cfg_i,
    input  wire video_gen_pkg::timing_ev_t    ev_i,
    input  wire video_gen_pkg::vram_data_t    vram_data_i,
    input  wire logic                         pending_full_i,
    output      logic                         vram_sel_o,
    output      video_gen_pkg::vram_addr_t    vram_addr_o,
    output      video_gen_pkg::pixel_group_t  group_o,
    output      logic                         group_wr_o
);
    import video_gen_pkg::*;

    video_cfg_t       snap;          // config for the current frame
    vram_addr_t       line_addr;
    vram_addr_t       word_addr;
    logic [2:0]       slot_cycle;
    logic [2:0]       num_words;
    logic [2:0]       word_idx;
    logic             issue;
    logic             capture;
    logic             hand_off;
    vram_data_t [3:0] words;
    logic [31:0]      nibbles;

    // ev_i.fetch_active is already low on disabled frames
    always_comb begin
        num_words  = (snap.bpp == BPP_8) ? 3'd4 : 3'd2;
        word_idx   = slot_cycle - 3'd2;                 // read data lags select by two
        issue      = ev_i.fetch_active && (slot_cycle < num_words);
        capture    = ev_i.fetch_active && (word_idx < num_words);   // wraps high for 0 and 1
        hand_off   = ev_i.fetch_active && (slot_cycle == 3'd7);
        group_wr_o = hand_off && !pending_full_i;
    end

    // expand collected words, high part of a word first
    always_comb begin
        nibbles = {words[0], words[1]};
        if (snap.bpp == BPP_8) begin
            group_o = {words[0], words[1], words[2], words[3]};
        end else begin
            for (int i = 0; i < 8; i++) begin
                group_o[7-i] = {snap.colorbase[7:4], nibbles[31-4*i -: 4]};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            slot_cycle <= '0;
            vram_sel_o <= 1'b0;
        end else begin
            vram_sel_o <= issue;
            if (ev_i.line_fetch_start) begin
                slot_cycle <= '0;
            end else if (ev_i.fetch_active && !(hand_off && pending_full_i)) begin
                slot_cycle <= slot_cycle + 1'b1;         // hold at hand-off while full
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ev_i.frame_start) begin
            snap      <= cfg_i;
            line_addr <= cfg_i.start_addr;
            word_addr <= cfg_i.start_addr;
        end else if (ev_i.line_end) begin
            line_addr <= line_addr + snap.line_width;
            word_addr <= line_addr + snap.line_width;
        end else if (issue) begin
            word_addr <= word_addr + 1'b1;
        end

        if (issue) begin
            vram_addr_o <= word_addr;
        end
        if (capture) begin
            words[word_idx[1:0]] <= vram_data_i;
        end
    end

    // no select may spill past the end of the window
    assert property (@(posedge clk) disable iff (reset_i)
        vram_sel_o |-> ev_i.fetch_active);

endmodule

`default_nettype wire

//--- hdl/pixel_shifter.sv
// ####################
// pending group buffer and pixel shift-out
// ####################
`default_nettype none
`timescale 1ns/10ps

module pixel_shifter (
    input  wire logic                         clk,
    input  wire logic                         reset_i,
    input  wire video_gen_pkg::timing_ev_t    ev_i,
    input  wire video_gen_pkg::pixel_group_t  group_i,
    input  wire logic                         group_wr_i,
    output      logic                         pending_full_o,
    output      video_gen_pkg::pal_index_t    pal_index_o
);
    import video_gen_pkg::*;

    pixel_group_t pending;
    pixel_group_t shift_q;
    logic [2:0]   pix_count;
    logic         load;

    always_comb load = ev_i.scanout_start || (ev_i.visible && pix_count == 3'd7);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pending_full_o <= 1'b0;
            pix_count      <= '0;
            pal_index_o    <= '0;
        end else begin
            if (load) begin
                pending_full_o <= 1'b0;
            end
            if (group_wr_i) begin
                pending_full_o <= 1'b1;
            end
            pix_count   <= ev_i.scanout_start ? 3'd0 : pix_count + ev_i.visible;
            pal_index_o <= ev_i.visible ? shift_q[7] : '0;   // black outside display
        end
    end

    always_ff @(posedge clk) begin
        if (group_wr_i) begin
            pending <= group_i;
        end
        if (load) begin
            shift_q <= pending;
        end else if (ev_i.visible) begin
            shift_q <= {shift_q[6:0], 8'h00};
        end
    end

    // fetch must stay ahead of scan-out
    assert property (@(posedge clk) disable iff (reset_i) load |-> pending_full_o);

endmodule

`default_nettype wire

//--- hdl/video_gen.sv
// ####################
// raster video generator top
// ####################
`default_nettype none
`timescale 1ns/10ps

module video_gen (
    input  wire logic                       clk,
    input  wire logic                       reset_i,
    input  wire logic                       enable_i,
    input  wire logic                       vgen_reg_wr_i,
    input  wire video_gen_pkg::reg_num_t    vgen_reg_num_i,
    input  wire video_gen_pkg::vram_data_t  vgen_reg_data_i,
    output      video_gen_pkg::vram_data_t  vgen_reg_data_o,
    input  wire video_gen_pkg::vram_data_t  vram_data_i,
    output      logic                       vram_sel_o,
    output      video_gen_pkg::vram_addr_t  vram_addr_o,
    output      video_gen_pkg::pal_index_t  pal_index_o,
    output      logic                       hsync_o,
    output      logic                       vsync_o,
    output      logic                       dv_de_o,
    output      logic                       bus_intr_o
);
    import video_gen_pkg::*;

    video_cfg_t   cfg;
    timing_ev_t   ev;
    pixel_group_t group;
    logic         group_wr;
    logic         pending_full;

    video_regs regs (
        .clk         (clk),
        .reset_i     (reset_i),
        .reg_wr_i    (vgen_reg_wr_i),
        .reg_num_i   (vgen_reg_num_i),
        .reg_data_i  (vgen_reg_data_i),
        .v_count_i   (ev.scanline),
        .v_visible_i (ev.v_visible),
        .h_visible_i (ev.h_visible),
        .reg_data_o  (vgen_reg_data_o),
        .cfg_o       (cfg)
    );

    video_timing timing (
        .clk        (clk),
        .reset_i    (reset_i),
        .enable_i   (enable_i),
        .ev_o       (ev),
        .hsync_o    (hsync_o),
        .vsync_o    (vsync_o),
        .dv_de_o    (dv_de_o),
        .bus_intr_o (bus_intr_o)
    );

    pixel_fetch fetch (
        .clk            (clk),
        .reset_i        (reset_i),
        .cfg_i          (cfg),
        .ev_i           (ev),
        .vram_data_i    (vram_data_i),
        .pending_full_i (pending_full),
        .vram_sel_o     (vram_sel_o),
        .vram_addr_o    (vram_addr_o),
        .group_o        (group),
        .group_wr_o     (group_wr)
    );

    pixel_shifter shifter (
        .clk            (clk),
        .reset_i        (reset_i),
        .ev_i           (ev),
        .group_i        (group),
        .group_wr_i     (group_wr),
        .pending_full_o (pending_full),
        .pal_index_o    (pal_index_o)
    );

endmodule

`default_nettype wire

//--- verification/video_model.svh
// ####################
// reference model for VRAM contents and expected pixels
// ####################
`ifndef VIDEO_MODEL_SVH
`define VIDEO_MODEL_SVH

localparam logic [31:0] LCG_SEED = 32'h0df2_853b;

// numerical recipes constants
function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
endfunction

// one LCG step over seed and address, the upper half mixes every address bit
function automatic vram_data_t vram_word(input vram_addr_t addr);
    logic [31:0] mixed;
    mixed = lcg_next(LCG_SEED ^ {addr, ~addr});
    return mixed[31:16];
endfunction

// pixel at column x of line y for a frame shown with cfg
function automatic pal_index_t expected_pixel(input video_cfg_t cfg, input int x, input int y);
    vram_addr_t line_base;
    vram_data_t w_data;
    logic [3:0] nib;
    line_base = vram_addr_t'(cfg.start_addr + y * cfg.line_width);   // wraps at 16 bits
    if (cfg.bpp == BPP_8) begin
        w_data = vram_word(vram_addr_t'(line_base + x / 2));
        return (x % 2 == 0) ? w_data[15:8] : w_data[7:0];             // high byte first
    end
    w_data = vram_word(vram_addr_t'(line_base + x / 4));
    nib    = w_data[4 * (3 - x % 4) +: 4];
    return {cfg.colorbase[7:4], nib};
endfunction

`endif

//--- verification/video_gen_tb.sv
// ####################
// video generator testbench with VRAM model and pixel checks
// ####################
`default_nettype none
`timescale 1ns/10ps

module video_gen_tb;
    import video_gen_pkg::*;

    `include "video_model.svh"

    localparam int FRAME_CYCLES = TOTAL_WIDTH * TOTAL_HEIGHT;

    logic       clk;
    logic       reset_i;
    logic       enable_i;
    logic       vgen_reg_wr_i;
    reg_num_t   vgen_reg_num_i;
    vram_data_t vgen_reg_data_i;
    vram_data_t vgen_reg_data_o;
    vram_data_t vram_data_i;
    logic       vram_sel_o;
    vram_addr_t vram_addr_o;
    pal_index_t pal_index_o;
    logic       hsync_o;
    logic       vsync_o;
    logic       dv_de_o;
    logic       bus_intr_o;

    video_cfg_t  model_cfg;   // config the next frames are shown with
    vram_data_t  ctrl_written;
    logic [31:0] rng_state;
    vram_data_t  rd_data;

    video_gen UUT (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // synchronous VRAM, one cycle read latency
    always @(posedge clk) begin : vram_model
        logic       sel;
        vram_addr_t addr;
        sel  = vram_sel_o;
        addr = vram_addr_o;
        #1;
        if (sel) begin
            vram_data_i = vram_word(addr);
        end
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped at first failure");
    endtask

    task automatic check_pixel(input string name, input pal_index_t exp, input pal_index_t act);
        if (act !== exp) begin
            abort_run($sformatf("Error: %s expected %02h actual %02h", name, exp, act));
        end
    endtask

    task automatic check_reg(input string name, input vram_data_t exp, input vram_data_t act);
        if (act !== exp) begin
            abort_run($sformatf("Error: %s expected %04h actual %04h", name, exp, act));
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            abort_run($sformatf("Error: %s expected %0d actual %0d", name, exp, act));
        end
    endtask

    function automatic vram_data_t rand_word();
        rng_state = lcg_next(rng_state);
        return rng_state[31:16];
    endfunction

    task automatic write_reg(input reg_num_t num, input vram_data_t data);
        @(posedge clk);
        #1;
        vgen_reg_wr_i   = 1'b1;
        vgen_reg_num_i  = num;
        vgen_reg_data_i = data;
        @(posedge clk);
        #1 vgen_reg_wr_i = 1'b0;
    endtask

    // data shows one cycle after the number
    task automatic read_reg(input reg_num_t num, output vram_data_t data);
        @(posedge clk);
        #1 vgen_reg_num_i = num;
        @(posedge clk);
        @(negedge clk);
        data = vgen_reg_data_o;
    endtask

    task automatic set_config(input vram_data_t start, input vram_data_t width,
                              input vram_data_t ctrl);
        write_reg(REG_DISPSTART, start);
        write_reg(REG_DISPWIDTH, width);
        write_reg(REG_GFXCTRL, ctrl);
        ctrl_written         = ctrl;
        model_cfg.start_addr = start;
        model_cfg.line_width = width;
        model_cfg.colorbase  = ctrl[15:8];
        model_cfg.bpp        = bpp_t'(ctrl[4]);
    endtask

    task automatic set_enable(input logic en);
        @(posedge clk);
        #1 enable_i = en;
    endtask

    task automatic wait_vsync_rise();
        int   cycles = 0;
        logic prev;
        logic seen = 1'b0;
        @(negedge clk);
        prev = vsync_o;
        while (!seen) begin
            @(negedge clk);
            cycles++;
            if (cycles > 2 * FRAME_CYCLES) begin
                abort_run("timed out waiting for vsync to rise");
            end
            seen = vsync_o && !prev;
            prev = vsync_o;
        end
    endtask

    // one full frame from vsync rise to vsync rise
    task automatic capture_frame(input string name, input logic expect_on);
        int         cycles = 0;
        int         pixels = 0;
        int         pulses = 0;
        int         run    = 0;
        int         sels   = 0;
        int         intrs  = 0;
        int         vs_on  = 0;
        int         late   = 0;   // pixels seen after the interrupt
        logic       prev_h;
        logic       prev_v;
        logic       done   = 1'b0;
        pal_index_t exp_pix;
        wait_vsync_rise();
        prev_h = hsync_o;
        prev_v = vsync_o;
        while (!done) begin
            @(negedge clk);
            cycles++;
            if (cycles > 2 * FRAME_CYCLES) begin
                abort_run($sformatf("%s: frame did not end within two frame times", name));
            end
            if (dv_de_o) begin
                exp_pix = expected_pixel(model_cfg, pixels % VISIBLE_WIDTH,
                                         pixels / VISIBLE_WIDTH);
                check_pixel($sformatf("%s pixel %0d", name, pixels), exp_pix, pal_index_o);
                pixels++;
                late += (intrs != 0);
            end else begin
                check_pixel({name, " blank index"}, 8'h00, pal_index_o);
            end
            sels  += vram_sel_o;
            intrs += bus_intr_o;
            vs_on += vsync_o;
            if (hsync_o && !prev_h) begin
                pulses++;
            end
            if (hsync_o) begin
                run++;
            end else if (prev_h) begin
                check_count({name, " hsync width"}, H_SYNC_PULSE, run);
                run = 0;
            end
            done   = vsync_o && !prev_v;
            prev_h = hsync_o;
            prev_v = vsync_o;
        end
        check_count({name, " hsync pulses"}, TOTAL_HEIGHT, pulses);
        check_count({name, " vsync cycles"}, V_SYNC_PULSE * TOTAL_WIDTH, vs_on);
        check_count({name, " de cycles"}, expect_on ? VISIBLE_WIDTH * VISIBLE_HEIGHT : 0, pixels);
        if (!expect_on) begin
            check_count({name, " vram selects"}, 0, sels);
        end
        check_count({name, " interrupts"}, 1, intrs);
        check_count({name, " de after interrupt"}, 0, late);
    endtask

    initial begin
        rng_state       = LCG_SEED;
        reset_i         = 1'b1;
        enable_i        = 1'b1;
        vgen_reg_wr_i   = 1'b0;
        vgen_reg_num_i  = '0;
        vgen_reg_data_i = '0;
        vram_data_i     = '0;
        ctrl_written    = '0;
        model_cfg       = '{start_addr: 16'h0000, line_width: 16'(VISIBLE_WIDTH / 2),
                            colorbase: 8'h00, bpp: BPP_8};
        repeat (4) @(posedge clk);
        #1 reset_i = 1'b0;

        capture_frame("reset frame", 1'b1);

        set_config(rand_word(), rand_word(), rand_word());
        read_reg(REG_DISPSTART, rd_data);
        check_reg("start readback", model_cfg.start_addr, rd_data);
        read_reg(REG_DISPWIDTH, rd_data);
        check_reg("width readback", model_cfg.line_width, rd_data);
        read_reg(REG_GFXCTRL, rd_data);
        check_reg("gfxctrl readback", ctrl_written & 16'hff10, rd_data);   // colorbase and bpp
        read_reg(REG_R_WIDTH, rd_data);
        check_reg("visible width", 16'(VISIBLE_WIDTH), rd_data);
        read_reg(REG_R_HEIGHT, rd_data);
        check_reg("visible height", 16'(VISIBLE_HEIGHT), rd_data);
        read_reg(4'd5, rd_data);
        check_reg("unused register", 16'h0000, rd_data);
        wait_vsync_rise();
        read_reg(REG_R_SCANLINE, rd_data);
        check_reg("scanline in vsync", 16'h8000, rd_data & 16'h8000);

        set_config(rand_word(), rand_word(), rand_word() | 16'h0010);   // 8 bpp
        capture_frame("8bpp frame", 1'b1);
        set_config(rand_word(), rand_word(), rand_word() & 16'hffef);   // 4 bpp
        capture_frame("4bpp frame", 1'b1);

        set_enable(1'b0);
        capture_frame("enable off", 1'b0);
        set_enable(1'b1);
        capture_frame("re-enabled frame", 1'b1);

        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

//--- video_gen.f
+incdir+verification
hdl/video_gen_pkg.sv
hdl/video_regs.sv
hdl/video_timing.sv
hdl/pixel_fetch.sv
hdl/pixel_shifter.sv
hdl/video_gen.sv
verification/video_gen_tb.sv

//--- Bender.yml
package:
  name: video_gen

sources:
  - hdl/video_gen_pkg.sv
  - hdl/video_regs.sv
  - hdl/video_timing.sv
  - hdl/pixel_fetch.sv
  - hdl/pixel_shifter.sv
  - hdl/video_gen.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/video_gen_tb.sv
